// File: logic/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// AXI side address width
`define BRIDGE_ADDR_W 32

// one AXI data beat, 4 bytes
`define BRIDGE_BEAT_W 32

// beats in one incrementing burst
`define BRIDGE_BEATS 16

// full cache line, BEATS x BEAT_W
`define BRIDGE_LINE_W 512

// read ports: 0 = instruction, 1 = data
`define BRIDGE_RD_PORTS 2

`endif

// File: logic/bridge_pkg.sv
`include "bridge_macros.svh"

package bridge_pkg;

    typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
    typedef logic [`BRIDGE_BEAT_W-1:0] beat_t;

    // beat k sits at bits 32k+31 : 32k, first beat lowest
    typedef logic [`BRIDGE_LINE_W-1:0] line_t;

    // AXI burst encoding, only INCR is driven
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

endpackage

// File: logic/read_arbiter.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module read_arbiter (
    input  logic                          aclk,
    input  logic                          aresetn,

    input  logic [`BRIDGE_RD_PORTS-1:0]   i_rd_req,
    input  bridge_pkg::addr_t             i_rd_addr [`BRIDGE_RD_PORTS],

    output logic [3:0]                    o_ar_id,
    output bridge_pkg::addr_t             o_ar_addr,
    output logic [7:0]                    o_ar_len,
    output logic [2:0]                    o_ar_size,
    output bridge_pkg::burst_t            o_ar_burst,
    output logic                          o_ar_valid,
    input  logic                          i_ar_ready,

    input  logic                          i_r_valid,
    input  logic                          i_r_last,
    output logic                          o_r_ready,

    output logic [`BRIDGE_RD_PORTS-1:0]   o_beat_valid,
    output logic                          o_beat_last
);

    localparam int GRANT_W = (`BRIDGE_RD_PORTS > 1) ? $clog2(`BRIDGE_RD_PORTS) : 1;

    bridge_pkg::rd_state_t          state_q;
    logic [GRANT_W-1:0]             grant_q;
    bridge_pkg::addr_t              addr_q;
    logic                           fin_q;       // done cycle of the last burst
    logic [`BRIDGE_RD_PORTS-1:0]    req_eff;
    logic [GRANT_W-1:0]             pick;
    logic                           r_hs;

    // the finished requester still holds its request in the done cycle
    always_comb
    begin
        req_eff = i_rd_req;
        if (fin_q)
            req_eff[grant_q] = 1'b0;
    end

    // fixed priority where the highest index wins
    always_comb
    begin
        pick = '0;
        for (int p = 0; p < `BRIDGE_RD_PORTS; p++)
        begin
            if (req_eff[p])
                pick = GRANT_W'(p);
        end
    end

    assign r_hs = i_r_valid & o_r_ready;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state_q <= bridge_pkg::RD_IDLE;
            grant_q <= '0;
            fin_q   <= 1'b0;
        end
        else
        begin
            fin_q <= r_hs & i_r_last;
            case (state_q)
                bridge_pkg::RD_IDLE:
                begin
                    if (|req_eff)
                    begin
                        grant_q <= pick;
                        state_q <= bridge_pkg::RD_ADDR;
                    end
                end
                bridge_pkg::RD_ADDR:
                    if (i_ar_ready)
                        state_q <= bridge_pkg::RD_DATA;
                bridge_pkg::RD_DATA:
                    if (r_hs && i_r_last)
                        state_q <= bridge_pkg::RD_IDLE;
                default:
                    state_q <= bridge_pkg::RD_IDLE;
            endcase
        end
    end

    // address latched together with the grant
    always_ff @(posedge aclk)
    begin
        if (state_q == bridge_pkg::RD_IDLE && |req_eff)
            addr_q <= i_rd_addr[pick];
    end

    assign o_ar_id    = {{(4-GRANT_W){1'b0}}, grant_q};
    assign o_ar_addr  = addr_q;
    assign o_ar_len   = 8'(`BRIDGE_BEATS - 1);
    assign o_ar_size  = 3'($clog2(`BRIDGE_BEAT_W / 8));
    assign o_ar_burst = bridge_pkg::BURST_INCR;
    assign o_ar_valid = (state_q == bridge_pkg::RD_ADDR);
    assign o_r_ready  = (state_q == bridge_pkg::RD_DATA);   // never back-pressure

    // steer each accepted beat to the granted assembler
    always_comb
    begin
        for (int p = 0; p < `BRIDGE_RD_PORTS; p++)
            o_beat_valid[p] = r_hs && (grant_q == GRANT_W'(p));
    end

    assign o_beat_last = i_r_last;

endmodule

// File: logic/line_assembler.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module line_assembler (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                i_beat_valid,
    input  logic                i_beat_last,
    input  bridge_pkg::beat_t   i_r_data,
    output bridge_pkg::line_t   o_rd_line,
    output logic                o_rd_done
);

    localparam int BUF_W = `BRIDGE_LINE_W - `BRIDGE_BEAT_W;

    // first 15 beats, newest at the top
    logic [BUF_W-1:0] buf_q;

    always_ff @(posedge aclk)
    begin
        if (i_beat_valid)
        begin
            buf_q <= {i_r_data, buf_q[BUF_W-1:`BRIDGE_BEAT_W]};
            if (i_beat_last)
                o_rd_line <= {i_r_data, buf_q};   // last beat goes straight on top
        end
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            o_rd_done <= 1'b0;
        else
            o_rd_done <= i_beat_valid & i_beat_last;   // one cycle pulse
    end

endmodule

// File: logic/line_writer.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module line_writer (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                i_wr_req,
    input  bridge_pkg::addr_t   i_wr_addr,
    input  bridge_pkg::line_t   i_wr_line,

    output bridge_pkg::addr_t   o_aw_addr,
    output logic [7:0]          o_aw_len,
    output logic [2:0]          o_aw_size,
    output bridge_pkg::burst_t  o_aw_burst,
    output logic                o_aw_valid,
    input  logic                i_aw_ready,

    output bridge_pkg::beat_t   o_w_data,
    output logic                o_w_valid,
    output logic                o_w_last,
    input  logic                i_w_ready,

    input  logic                i_b_valid,
    output logic                o_b_ready,

    output logic                o_wr_done
);

    localparam int CNT_W = $clog2(`BRIDGE_BEATS);

    bridge_pkg::wr_state_t  state_q;
    bridge_pkg::addr_t      addr_q;
    bridge_pkg::line_t      line_q;      // lowest beat is the next to go
    logic [CNT_W-1:0]       cnt_q;
    logic                   start;
    logic                   w_hs;

    // ignore the request while done is still high, cache drops it next cycle
    assign start = (state_q == bridge_pkg::WR_IDLE) && i_wr_req && !o_wr_done;
    assign w_hs  = o_w_valid & i_w_ready;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state_q   <= bridge_pkg::WR_IDLE;
            cnt_q     <= '0;
            o_wr_done <= 1'b0;
        end
        else
        begin
            o_wr_done <= 1'b0;
            case (state_q)
                bridge_pkg::WR_IDLE:
                begin
                    if (start)
                    begin
                        cnt_q   <= '0;
                        state_q <= bridge_pkg::WR_ADDR;
                    end
                end
                bridge_pkg::WR_ADDR:
                    if (i_aw_ready)
                        state_q <= bridge_pkg::WR_DATA;
                bridge_pkg::WR_DATA:
                begin
                    if (w_hs)
                    begin
                        cnt_q <= cnt_q + 1'b1;
                        if (o_w_last)
                            state_q <= bridge_pkg::WR_RESP;
                    end
                end
                bridge_pkg::WR_RESP:
                begin
                    if (i_b_valid)
                    begin
                        o_wr_done <= 1'b1;
                        state_q   <= bridge_pkg::WR_IDLE;
                    end
                end
                default:
                    state_q <= bridge_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (start)
        begin
            addr_q <= i_wr_addr;
            line_q <= i_wr_line;
        end
        else if (w_hs)
            line_q <= {{`BRIDGE_BEAT_W{1'b0}}, line_q[`BRIDGE_LINE_W-1:`BRIDGE_BEAT_W]};
    end

    assign o_aw_addr  = addr_q;
    assign o_aw_len   = 8'(`BRIDGE_BEATS - 1);
    assign o_aw_size  = 3'($clog2(`BRIDGE_BEAT_W / 8));
    assign o_aw_burst = bridge_pkg::BURST_INCR;
    assign o_aw_valid = (state_q == bridge_pkg::WR_ADDR);

    assign o_w_data  = line_q[`BRIDGE_BEAT_W-1:0];
    assign o_w_valid = (state_q == bridge_pkg::WR_DATA);
    assign o_w_last  = o_w_valid && (cnt_q == CNT_W'(`BRIDGE_BEATS - 1));   // 16th beat
    assign o_b_ready = (state_q == bridge_pkg::WR_RESP);

endmodule

// File: logic/axi_line_bridge.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module axi_line_bridge (
    input  logic                          aclk,
    input  logic                          aresetn,

    // cache read ports, 0 = instruction, 1 = data
    input  logic [`BRIDGE_RD_PORTS-1:0]   i_rd_req,
    input  bridge_pkg::addr_t             i_rd_addr [`BRIDGE_RD_PORTS],
    output bridge_pkg::line_t             o_rd_line [`BRIDGE_RD_PORTS],
    output logic [`BRIDGE_RD_PORTS-1:0]   o_rd_done,

    // data cache write port
    input  logic                          i_wr_req,
    input  bridge_pkg::addr_t             i_wr_addr,
    input  bridge_pkg::line_t             i_wr_line,
    output logic                          o_wr_done,

    output logic [3:0]                    o_ar_id,
    output bridge_pkg::addr_t             o_ar_addr,
    output logic [7:0]                    o_ar_len,
    output logic [2:0]                    o_ar_size,
    output bridge_pkg::burst_t            o_ar_burst,
    output logic                          o_ar_valid,
    input  logic                          i_ar_ready,

    input  bridge_pkg::beat_t             i_r_data,
    input  logic                          i_r_last,
    input  logic                          i_r_valid,
    output logic                          o_r_ready,

    output bridge_pkg::addr_t             o_aw_addr,
    output logic [7:0]                    o_aw_len,
    output logic [2:0]                    o_aw_size,
    output bridge_pkg::burst_t            o_aw_burst,
    output logic                          o_aw_valid,
    input  logic                          i_aw_ready,

    output bridge_pkg::beat_t             o_w_data,
    output logic                          o_w_valid,
    output logic                          o_w_last,
    input  logic                          i_w_ready,

    input  logic                          i_b_valid,
    output logic                          o_b_ready
);

    logic [`BRIDGE_RD_PORTS-1:0] beat_valid;   // R handshake per port
    logic                        beat_last;

    read_arbiter u_read_arbiter (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_rd_req     (i_rd_req),
        .i_rd_addr    (i_rd_addr),
        .o_ar_id      (o_ar_id),
        .o_ar_addr    (o_ar_addr),
        .o_ar_len     (o_ar_len),
        .o_ar_size    (o_ar_size),
        .o_ar_burst   (o_ar_burst),
        .o_ar_valid   (o_ar_valid),
        .i_ar_ready   (i_ar_ready),
        .i_r_valid    (i_r_valid),
        .i_r_last     (i_r_last),
        .o_r_ready    (o_r_ready),
        .o_beat_valid (beat_valid),
        .o_beat_last  (beat_last)
    );

    // one assembler per read port, all fed from the shared R data
    for (genvar p = 0; p < `BRIDGE_RD_PORTS; p++)
    begin : g_asm
        line_assembler u_line_assembler (
            .aclk         (aclk),
            .aresetn      (aresetn),
            .i_beat_valid (beat_valid[p]),
            .i_beat_last  (beat_last),
            .i_r_data     (i_r_data),
            .o_rd_line    (o_rd_line[p]),
            .o_rd_done    (o_rd_done[p])
        );
    end

    line_writer u_line_writer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_req   (i_wr_req),
        .i_wr_addr  (i_wr_addr),
        .i_wr_line  (i_wr_line),
        .o_aw_addr  (o_aw_addr),
        .o_aw_len   (o_aw_len),
        .o_aw_size  (o_aw_size),
        .o_aw_burst (o_aw_burst),
        .o_aw_valid (o_aw_valid),
        .i_aw_ready (i_aw_ready),
        .o_w_data   (o_w_data),
        .o_w_valid  (o_w_valid),
        .o_w_last   (o_w_last),
        .i_w_ready  (i_w_ready),
        .i_b_valid  (i_b_valid),
        .o_b_ready  (o_b_ready),
        .o_wr_done  (o_wr_done)
    );

endmodule

// File: tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int          WORDS = 4096,
    parameter logic [31:0] SEED  = 32'h8ddc_99cc
) (
    input  logic        aclk,
    input  logic        aresetn,

    input  logic [31:0] i_ar_addr,
    input  logic [7:0]  i_ar_len,
    input  logic        i_ar_valid,
    output logic        o_ar_ready,

    output logic [31:0] o_r_data,
    output logic        o_r_last,
    output logic        o_r_valid,
    input  logic        i_r_ready,

    input  logic [31:0] i_aw_addr,
    input  logic        i_aw_valid,
    output logic        o_aw_ready,

    input  logic [31:0] i_w_data,
    input  logic        i_w_last,
    input  logic        i_w_valid,
    output logic        o_w_ready,

    output logic        o_b_valid,
    input  logic        i_b_ready
);

    localparam int IDX_W = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    integer           seed;
    logic             rd_busy;
    logic [IDX_W-1:0] rd_ptr;
    logic [7:0]       rd_cnt;     // beats left after the current one
    logic             wr_busy;
    logic [IDX_W-1:0] wr_ptr;

    // high three times in four
    function automatic logic roll();
        return ($random(seed) & 3) != 0;
    endfunction

    initial
    begin
        seed = SEED;
        // word a holds a * 0x10003 ^ 0xa5c30f1e
        for (int i = 0; i < WORDS; i++)
            mem[IDX_W'(i)] = (32'(i) * 32'h0001_0003) ^ 32'ha5c3_0f1e;
    end

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_ar_ready <= 1'b0;
            o_r_valid  <= 1'b0;
            rd_busy    <= 1'b0;
            rd_ptr     <= '0;
            rd_cnt     <= '0;
        end
        else
        begin
            if (i_ar_valid && o_ar_ready)
            begin
                o_ar_ready <= 1'b0;
                rd_busy    <= 1'b1;
                rd_ptr     <= i_ar_addr[IDX_W+1:2];
                rd_cnt     <= i_ar_len;
            end
            else
                o_ar_ready <= !rd_busy && roll();
            if (o_r_valid && i_r_ready)
            begin
                rd_ptr    <= rd_ptr + 1'b1;
                rd_cnt    <= rd_cnt - 1'b1;
                rd_busy   <= !o_r_last;
                o_r_valid <= !o_r_last && roll();
            end
            else if (rd_busy && !o_r_valid)
                o_r_valid <= roll();    // valid holds once raised
        end
    end

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_b_valid  <= 1'b0;
            wr_busy    <= 1'b0;
            wr_ptr     <= '0;
        end
        else
        begin
            if (i_aw_valid && o_aw_ready)
            begin
                o_aw_ready <= 1'b0;
                wr_busy    <= 1'b1;
                wr_ptr     <= i_aw_addr[IDX_W+1:2];
            end
            else
                o_aw_ready <= !wr_busy && roll();
            if (o_w_ready && i_w_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
                if (i_w_last)
                begin
                    o_w_ready <= 1'b0;
                    o_b_valid <= 1'b1;
                end
                else
                    o_w_ready <= roll();
            end
            else if (wr_busy && !o_b_valid)
                o_w_ready <= roll();
            if (o_b_valid && i_b_ready)
            begin
                o_b_valid <= 1'b0;
                wr_busy   <= 1'b0;
            end
        end
    end

    always @(posedge aclk)
    begin
        if (o_w_ready && i_w_valid)
            mem[wr_ptr] <= i_w_data;
    end

    assign o_r_data = mem[rd_ptr];
    assign o_r_last = (rd_cnt == 8'd0);

endmodule

// File: tb/tb_axi_line_bridge.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_axi_line_bridge;

    localparam int IDX_W = 12;   // model holds 4096 words
    // 22 line bursts at roughly 35 stalled cycles each leave a wide margin
    localparam int TIMEOUT_CYC = 4000;

    logic                          aclk;
    logic                          aresetn;
    logic [`BRIDGE_RD_PORTS-1:0]   rd_req;
    bridge_pkg::addr_t             rd_addr [`BRIDGE_RD_PORTS];
    bridge_pkg::line_t             rd_line [`BRIDGE_RD_PORTS];
    logic [`BRIDGE_RD_PORTS-1:0]   rd_done;
    logic                          wr_req;
    bridge_pkg::addr_t             wr_addr;
    bridge_pkg::line_t             wr_line;
    logic                          wr_done;

    logic [3:0]          ar_id;
    bridge_pkg::addr_t   ar_addr;
    logic [7:0]          ar_len;
    logic [2:0]          ar_size;
    bridge_pkg::burst_t  ar_burst;
    logic                ar_valid;
    logic                ar_ready;
    bridge_pkg::beat_t   r_data;
    logic                r_last;
    logic                r_valid;
    logic                r_ready;
    bridge_pkg::addr_t   aw_addr;
    logic [7:0]          aw_len;
    logic [2:0]          aw_size;
    bridge_pkg::burst_t  aw_burst;
    logic                aw_valid;
    logic                aw_ready;
    bridge_pkg::beat_t   w_data;
    logic                w_valid;
    logic                w_last;
    logic                w_ready;
    logic                b_valid;
    logic                b_ready;

    int          errors = 0;
    int          cycles = 0;
    integer      seed;
    logic [31:0] shadow [2**IDX_W];   // expected memory contents

    axi_line_bridge uut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_rd_req   (rd_req),
        .i_rd_addr  (rd_addr),
        .o_rd_line  (rd_line),
        .o_rd_done  (rd_done),
        .i_wr_req   (wr_req),
        .i_wr_addr  (wr_addr),
        .i_wr_line  (wr_line),
        .o_wr_done  (wr_done),
        .o_ar_id    (ar_id),
        .o_ar_addr  (ar_addr),
        .o_ar_len   (ar_len),
        .o_ar_size  (ar_size),
        .o_ar_burst (ar_burst),
        .o_ar_valid (ar_valid),
        .i_ar_ready (ar_ready),
        .i_r_data   (r_data),
        .i_r_last   (r_last),
        .i_r_valid  (r_valid),
        .o_r_ready  (r_ready),
        .o_aw_addr  (aw_addr),
        .o_aw_len   (aw_len),
        .o_aw_size  (aw_size),
        .o_aw_burst (aw_burst),
        .o_aw_valid (aw_valid),
        .i_aw_ready (aw_ready),
        .o_w_data   (w_data),
        .o_w_valid  (w_valid),
        .o_w_last   (w_last),
        .i_w_ready  (w_ready),
        .i_b_valid  (b_valid),
        .o_b_ready  (b_ready)
    );

    axi_mem_model #(.WORDS(2**IDX_W)) u_mem (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_ar_addr  (ar_addr),
        .i_ar_len   (ar_len),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .o_r_data   (r_data),
        .o_r_last   (r_last),
        .o_r_valid  (r_valid),
        .i_r_ready  (r_ready),
        .i_aw_addr  (aw_addr),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_w_data   (w_data),
        .i_w_last   (w_last),
        .i_w_valid  (w_valid),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .i_b_ready  (b_ready)
    );

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk)
        cycles <= cycles + 1;

    initial
    begin
        wait (cycles >= TIMEOUT_CYC);
        $display("timeout: run stopped after %0d cycles with %0d errors", cycles, errors);
        $display("Test failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // word a of memory before any write
    function automatic logic [31:0] pattern(input logic [IDX_W-1:0] word);
        return (32'(word) * 32'h0001_0003) ^ 32'ha5c3_0f1e;
    endfunction

    function automatic bridge_pkg::line_t expected_line(input bridge_pkg::addr_t addr);
        bridge_pkg::line_t l;
        logic [IDX_W-1:0]  base;
        base = addr[IDX_W+1:2];
        l = '0;
        for (int k = `BRIDGE_BEATS - 1; k >= 0; k--)
            l = {l[`BRIDGE_LINE_W-`BRIDGE_BEAT_W-1:0], shadow[base + IDX_W'(k)]};
        return l;   // beat 0 ends up lowest
    endfunction

    function automatic bridge_pkg::line_t random_line();
        bridge_pkg::line_t l;
        l = '0;
        repeat (`BRIDGE_BEATS)
            l = {l[`BRIDGE_LINE_W-`BRIDGE_BEAT_W-1:0], 32'($random(seed))};
        return l;
    endfunction

    // the data port wins whenever it requests
    function automatic int expected_grant();
        return rd_req[1] ? 1 : 0;
    endfunction

    // AR and AW attributes sampled mid-cycle
    always @(negedge aclk)
    begin
        if (ar_valid && ar_ready)
        begin
            check_val("o_ar_len", 512'(ar_len), 512'd15);
            check_val("o_ar_size", 512'(ar_size), 512'd2);
            check_val("o_ar_burst", 512'(ar_burst), 512'(bridge_pkg::BURST_INCR));
            check_val("o_ar_id", 512'(ar_id), 512'(expected_grant()));
            check_val("o_ar_addr", 512'(ar_addr), 512'(rd_addr[expected_grant()]));
        end
        if (aw_valid && aw_ready)
        begin
            check_val("o_aw_len", 512'(aw_len), 512'd15);
            check_val("o_aw_size", 512'(aw_size), 512'd2);
            check_val("o_aw_burst", 512'(aw_burst), 512'(bridge_pkg::BURST_INCR));
            check_val("o_aw_addr", 512'(aw_addr), 512'(wr_addr));
        end
    end

    // request held until done and dropped the cycle after
    task automatic read_line(input logic port, input bridge_pkg::addr_t addr,
                             output int done_cyc, output int other_done);
        rd_addr[port] = addr;
        rd_req[port]  = 1'b1;
        other_done    = 0;
        do
        begin
            @(posedge aclk);
            #1;
            if (rd_done[~port])
                other_done++;
        end
        while (!rd_done[port]);
        done_cyc = cycles;
        check_val($sformatf("o_rd_line[%0d]", port), rd_line[port], expected_line(addr));
        @(posedge aclk);
        #1;
        check_val($sformatf("o_rd_done[%0d] width", port), 512'(rd_done[port]), '0);
        rd_req[port] = 1'b0;
    endtask

    task automatic write_line(input bridge_pkg::addr_t addr, input bridge_pkg::line_t line);
        bridge_pkg::line_t rest;
        logic [IDX_W-1:0]  base;
        wr_addr = addr;
        wr_line = line;
        wr_req  = 1'b1;
        do
        begin
            @(posedge aclk);
            #1;
        end
        while (!wr_done);
        @(posedge aclk);
        #1;
        wr_req = 1'b0;
        base   = addr[IDX_W+1:2];
        rest   = line;
        for (int k = 0; k < `BRIDGE_BEATS; k++)
        begin
            shadow[base + IDX_W'(k)] = rest[`BRIDGE_BEAT_W-1:0];
            rest = rest >> `BRIDGE_BEAT_W;
        end
    endtask

    task automatic idle_after_reset();
        check_val("o_ar_valid", 512'(ar_valid), '0);
        check_val("o_aw_valid", 512'(aw_valid), '0);
        check_val("o_w_valid", 512'(w_valid), '0);
        check_val("o_b_ready", 512'(b_ready), '0);
        check_val("o_rd_done", 512'(rd_done), '0);
        check_val("o_wr_done", 512'(wr_done), '0);
    endtask

    task automatic single_port_read(input logic port, input bridge_pkg::addr_t addr);
        int cyc;
        int other;
        read_line(port, addr, cyc, other);
        check_val($sformatf("o_rd_done[%0d] pulses", ~port), 512'(other), '0);
    endtask

    // data port has priority when both ask together
    task automatic priority_read();
        int cyc0;
        int cyc1;
        int other0;
        int other1;
        fork
            read_line(1'b0, 32'h0000_0400, cyc0, other0);
            read_line(1'b1, 32'h0000_0800, cyc1, other1);
        join
        if (cyc1 >= cyc0)
        begin
            errors++;
            $display("port 1 did not finish before port 0 (cycles %0d and %0d)", cyc1, cyc0);
        end
    endtask

    task automatic write_then_read();
        bridge_pkg::line_t l;
        int                cyc;
        int                other;
        l = random_line();
        write_line(32'h0000_1000, l);
        read_line(1'b1, 32'h0000_1000, cyc, other);
        check_val("o_rd_line[1] after write", rd_line[1], l);
    endtask

    // small address window so reads often hit earlier writes
    task automatic mixed_traffic();
        bridge_pkg::addr_t addr;
        int                cyc;
        int                other;
        for (int n = 0; n < 16; n++)
        begin
            addr = 32'h0000_2000 + 32'(($random(seed) & 7) << 6);
            if (($random(seed) & 1) != 0)
                write_line(addr, random_line());
            else
                read_line(1'($random(seed)), addr, cyc, other);
        end
    endtask

    initial
    begin
        seed       = 32'h8ddc_99cc;
        aresetn    = 1'b0;
        rd_req     = '0;
        rd_addr[0] = '0;
        rd_addr[1] = '0;
        wr_req     = 1'b0;
        wr_addr    = '0;
        wr_line    = '0;
        for (int i = 0; i < 2**IDX_W; i++)
            shadow[IDX_W'(i)] = pattern(IDX_W'(i));
        repeat (5) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        idle_after_reset();
        single_port_read(1'b0, 32'h0000_0040);
        single_port_read(1'b1, 32'h0000_0c80);
        priority_read();
        write_then_read();
        mixed_traffic();
        repeat (2) @(posedge aclk);

        $display("%0d errors in %0d cycles", errors, cycles);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/bridge_pkg.sv
logic/read_arbiter.sv
logic/line_assembler.sv
logic/line_writer.sv
logic/axi_line_bridge.sv
tb/axi_mem_model.sv
tb/tb_axi_line_bridge.sv

// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing -j 0
TOP     = tb_axi_line_bridge
RTL_TOP = axi_line_bridge
FLIST   = compile.f
BUILD   = obj_dir
LOG     = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)
